/* source/mgnt_pkg.sv */
`default_nettype none

package mgnt_pkg;

    // Remote register payload
    localparam int MGNT_REG_WIDTH = 32;
    localparam int MGNT_BYTES     = MGNT_REG_WIDTH / 8;

    typedef enum logic [6:0] {
        OP_DEV_PTR    = 7'h00,
        OP_DEV_DATA   = 7'h01,
        OP_TABLE_CTRL = 7'h02,
        OP_TABLE_HASH = 7'h03,
        OP_TABLE_ST0  = 7'h30,
        OP_TABLE_ST1  = 7'h31,
        OP_TABLE_ST2  = 7'h32,
        OP_TABLE_ST3  = 7'h33,
        OP_TABLE_ST4  = 7'h34,
        OP_TABLE_ST5  = 7'h35,
        OP_TABLE_ST6  = 7'h36,
        OP_TABLE_ST7  = 7'h37
    } spi_op_t;

    typedef enum logic [6:0] {
        TGT_PORT0  = 7'h00,
        TGT_PORT1  = 7'h01,
        TGT_PORT2  = 7'h02,
        TGT_PORT3  = 7'h03,
        TGT_BE_SW  = 7'h40,
        TGT_TTE_SW = 7'h41,
        TGT_LOCAL  = 7'h7F
    } dev_target_t;

    typedef struct packed {
        logic        wr;
        dev_target_t target;
        logic [7:0]  addr;
    } dev_ptr_t;

    // Local registers behind TGT_LOCAL
    localparam logic [7:0] LOC_DEV_DATA   = 8'h01;
    localparam logic [7:0] LOC_TABLE_CTRL = 8'h02;
    localparam logic [7:0] LOC_TABLE_HASH = 8'h03;
    localparam logic [7:0] LOC_TABLE_ST   = 8'h30;

    typedef struct packed {
        logic [5:0] valid;
        logic       wr;
        logic [7:0] addr;
    } sys_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } sys_byte_t;

    typedef struct packed {
        spi_op_t     op;
        logic [15:0] din;
    } spi_cmd_t;

    typedef logic [119:0] flow_t;

    typedef enum logic [1:0] {
        FT_NONE,
        FT_UPDATE,
        FT_CLEAR
    } ft_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        LAUNCH,
        XFER,
        WAIT_ACK,
        LOCAL,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/flow_table.sv */
`default_nettype none

module flow_table
    import mgnt_pkg::*;
#(
    parameter int FT_DEPTH = 16
) (
    input  wire              clk,
    input  wire              rst,
    input  wire ft_cmd_t     ft_cmd,
    input  wire [11:0]       ft_hash,
    input  wire flow_t       ft_flow,
    output logic [1:0]       ft_busy,
    input  wire [11:0]       lookup_hash,
    output logic             lookup_hit,
    output flow_t            lookup_flow
);

    localparam int IDX_W = $clog2(FT_DEPTH);

    logic [FT_DEPTH-1:0] ent_valid;
    logic [11:0]         ent_tag [FT_DEPTH];
    flow_t               ent_flow [FT_DEPTH];
    logic                clr_busy;
    logic                upd_busy;
    logic [IDX_W-1:0]    clr_idx;
    logic                do_update;
    logic [IDX_W-1:0]    upd_idx;
    logic [IDX_W-1:0]    lkp_idx;
    logic                lkp_match;

    // Commands during a clear sweep are dropped
    assign do_update = ft_cmd == FT_UPDATE && !clr_busy;
    assign upd_idx   = ft_hash[IDX_W-1:0];
    assign lkp_idx   = lookup_hash[IDX_W-1:0];
    assign lkp_match = ent_valid[lkp_idx] && ent_tag[lkp_idx] == lookup_hash;
    assign ft_busy   = {clr_busy, upd_busy};

    always_ff @(posedge clk) begin
        if (do_update) begin
            ent_tag[upd_idx]  <= ft_hash;
            ent_flow[upd_idx] <= ft_flow;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ent_valid <= '0;
            clr_busy  <= 1'b0;
            upd_busy  <= 1'b0;
            clr_idx   <= '0;
        end else begin
            upd_busy <= do_update;
            if (clr_busy) begin
                ent_valid[clr_idx] <= 1'b0;
                clr_idx            <= clr_idx + 1'b1;
                if (clr_idx == IDX_W'(FT_DEPTH - 1)) begin
                    clr_busy <= 1'b0;
                end
            end else if (ft_cmd == FT_CLEAR) begin
                clr_busy <= 1'b1;
                clr_idx  <= '0;
            end else if (do_update) begin
                ent_valid[upd_idx] <= 1'b1;
            end
        end
    end

    // Registered lookup
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lookup_hit  <= 1'b0;
            lookup_flow <= '0;
        end else begin
            lookup_hit  <= lkp_match;
            lookup_flow <= lkp_match ? ent_flow[lkp_idx] : '0;
        end
    end

endmodule

`default_nettype wire

/* source/mgnt_dev_bank.sv */
`default_nettype none

module mgnt_dev_bank
    import mgnt_pkg::*;
#(
    parameter int DEV_REGS = 16
) (
    input  wire              clk,
    input  wire              rst,
    input  wire sys_req_t    sys_req,
    input  wire sys_byte_t   sys_tx,
    output sys_byte_t        sys_rx,
    output logic             sys_ack
);

    localparam int N_DEV     = 6;
    localparam int DEV_AW    = $clog2(DEV_REGS);
    localparam int MEM_DEPTH = N_DEV * DEV_REGS;
    localparam int MEM_AW    = $clog2(MEM_DEPTH);
    localparam int CNT_W     = $clog2(MGNT_BYTES);

    typedef enum logic [1:0] {
        B_IDLE,
        B_READ,
        B_HOLD
    } bank_state_t;

    bank_state_t               state;
    logic [MGNT_REG_WIDTH-1:0] mem [MEM_DEPTH];
    logic [MGNT_REG_WIDTH-1:0] wr_sr;
    logic [MGNT_REG_WIDTH-1:0] wr_word;
    logic [MGNT_REG_WIDTH-1:0] rd_sr;
    logic [CNT_W-1:0]          cnt;
    logic                      cnt_last;
    logic [MEM_AW-1:0]         mem_idx;

    function automatic logic [2:0] dev_index(input logic [5:0] onehot);
        logic [2:0] idx;
        idx = '0;
        for (int i = 0; i < N_DEV; i++) begin
            if (onehot[i]) begin
                idx = 3'(i);
            end
        end
        return idx;
    endfunction

    assign mem_idx  = MEM_AW'(dev_index(sys_req.valid)) * MEM_AW'(DEV_REGS)
                    + MEM_AW'(sys_req.addr[DEV_AW-1:0]);
    assign wr_word  = {wr_sr[MGNT_REG_WIDTH-9:0], sys_tx.data};
    assign cnt_last = cnt == CNT_W'(MGNT_BYTES - 1);

    // Response bytes, MSB first
    always_comb begin
        sys_rx.valid = state == B_READ;
        sys_rx.data  = rd_sr[MGNT_REG_WIDTH-1 -: 8];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= B_IDLE;
            cnt     <= '0;
            sys_ack <= 1'b0;
            wr_sr   <= '0;
            rd_sr   <= '0;
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            sys_ack <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (sys_req.valid != '0 && !sys_req.wr) begin
                        rd_sr <= mem[mem_idx];
                        cnt   <= '0;
                        state <= B_READ;
                    end else if (sys_req.valid != '0 && sys_tx.valid) begin
                        // Gather write bytes until the word is complete
                        if (cnt_last) begin
                            mem[mem_idx] <= wr_word;
                            cnt          <= '0;
                            sys_ack      <= 1'b1;
                            state        <= B_HOLD;
                        end else begin
                            wr_sr <= wr_word;
                            cnt   <= cnt + 1'b1;
                        end
                    end
                end
                B_READ: begin
                    rd_sr <= rd_sr << 8;
                    cnt   <= cnt + 1'b1;
                    if (cnt_last) begin
                        sys_ack <= 1'b1;
                        state   <= B_HOLD;
                    end
                end
                B_HOLD: begin
                    if (sys_req.valid == '0) begin
                        state <= B_IDLE;
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/mgnt_reg_ctrl.sv */
`default_nettype none

module mgnt_reg_ctrl
    import mgnt_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                spi_wr,
    input  wire spi_cmd_t      spi_cmd,
    output logic               spi_ack,
    output logic [15:0]        spi_dout,
    output sys_req_t           sys_req,
    output sys_byte_t          sys_tx,
    input  wire sys_byte_t     sys_rx,
    input  wire                sys_ack,
    output ft_cmd_t            ft_cmd,
    output logic [11:0]        ft_hash,
    output flow_t              ft_flow,
    input  wire [1:0]          ft_busy
);

    localparam int CNT_W = $clog2(MGNT_BYTES);

    ctrl_state_t               state;
    ctrl_state_t               state_next;
    spi_cmd_t                  cmd_q;
    dev_ptr_t                  ptr_in;
    dev_ptr_t                  dev_ptr;
    logic [15:0]               dev_data;
    logic [11:0]               tbl_hash;
    logic [127:0]              tbl_st;
    logic [MGNT_REG_WIDTH-1:0] tx_sr;
    logic [MGNT_REG_WIDTH-1:0] rx_sr;
    logic [CNT_W-1:0]          byte_cnt;
    logic                      byte_step;
    logic                      byte_last;
    logic [15:0]               local_word;

    // Endpoint one-hot select, zero for local or unknown targets
    function automatic logic [5:0] dev_select(input dev_target_t tgt);
        case (tgt)
            TGT_PORT0:  return 6'b000001;
            TGT_PORT1:  return 6'b000010;
            TGT_PORT2:  return 6'b000100;
            TGT_PORT3:  return 6'b001000;
            TGT_BE_SW:  return 6'b010000;
            TGT_TTE_SW: return 6'b100000;
            default:    return 6'b000000;
        endcase
    endfunction

    assign ptr_in    = dev_ptr_t'(cmd_q.din);
    assign byte_step = dev_ptr.wr ? 1'b1 : sys_rx.valid;
    assign byte_last = byte_cnt == CNT_W'(MGNT_BYTES - 1);
    assign spi_ack   = state == DONE;
    assign ft_hash   = tbl_hash;
    assign ft_flow   = tbl_st[119:0];

    ////////////////////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (spi_wr) begin
                    state_next = DECODE;
                end
            end
            DECODE: begin
                if (cmd_q.op == OP_DEV_PTR && dev_select(ptr_in.target) != '0) begin
                    state_next = LAUNCH;
                end else begin
                    state_next = LOCAL;
                end
            end
            LAUNCH: state_next = XFER;
            XFER: begin
                if (byte_step && byte_last) begin
                    state_next = WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (sys_ack) begin
                    state_next = DONE;
                end
            end
            LOCAL:   state_next = DONE;
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && spi_wr) begin
            cmd_q <= spi_cmd;
        end
    end

    // Pointer, data, staging and table command
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dev_ptr  <= '0;
            dev_data <= '0;
            tbl_hash <= '0;
            tbl_st   <= '0;
            ft_cmd   <= FT_NONE;
        end else begin
            ft_cmd <= FT_NONE;
            if (state == DECODE) begin
                case (cmd_q.op)
                    OP_DEV_PTR:    dev_ptr  <= ptr_in;
                    OP_DEV_DATA:   dev_data <= cmd_q.din;
                    OP_TABLE_HASH: tbl_hash <= cmd_q.din[11:0];
                    OP_TABLE_CTRL: begin
                        if (cmd_q.din == 16'd1) begin
                            ft_cmd <= FT_UPDATE;
                        end else if (cmd_q.din == 16'd2) begin
                            ft_cmd <= FT_CLEAR;
                        end
                    end
                    OP_TABLE_ST0, OP_TABLE_ST1, OP_TABLE_ST2, OP_TABLE_ST3,
                    OP_TABLE_ST4, OP_TABLE_ST5, OP_TABLE_ST6, OP_TABLE_ST7: begin
                        tbl_st[16*cmd_q.op[2:0] +: 16] <= cmd_q.din;
                    end
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Remote transfer
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sys_tx.valid = state == XFER && dev_ptr.wr;
        sys_tx.data  = tx_sr[MGNT_REG_WIDTH-1 -: 8];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sys_req  <= '0;
            tx_sr    <= '0;
            rx_sr    <= '0;
            byte_cnt <= '0;
        end else begin
            if (state == LAUNCH) begin
                sys_req.valid <= dev_select(dev_ptr.target);
                sys_req.wr    <= dev_ptr.wr;
                sys_req.addr  <= dev_ptr.addr;
                tx_sr         <= MGNT_REG_WIDTH'(dev_data);
                byte_cnt      <= '0;
            end else if (state == XFER && byte_step) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (dev_ptr.wr) begin
                    tx_sr <= tx_sr << 8;
                end else begin
                    rx_sr <= {rx_sr[MGNT_REG_WIDTH-9:0], sys_rx.data};
                end
            end else if (state == WAIT_ACK && sys_ack) begin
                sys_req <= '0;
            end
        end
    end

    // Local read-back and echo
    always_comb begin
        local_word = cmd_q.din;
        if (cmd_q.op == OP_DEV_PTR) begin
            local_word = '0;
            if (dev_ptr.target == TGT_LOCAL) begin
                case (dev_ptr.addr)
                    LOC_DEV_DATA:   local_word = dev_data;
                    LOC_TABLE_CTRL: local_word = {14'b0, ft_busy};
                    LOC_TABLE_HASH: local_word = {4'b0, tbl_hash};
                    default: begin
                        if (dev_ptr.addr[7:3] == LOC_TABLE_ST[7:3]) begin
                            local_word = tbl_st[16*dev_ptr.addr[2:0] +: 16];
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            spi_dout <= '0;
        end else if (state == LOCAL) begin
            spi_dout <= local_word;
        end else if (state == WAIT_ACK && sys_ack) begin
            // Writes echo the data sent, reads return the low half
            spi_dout <= dev_ptr.wr ? dev_data : rx_sr[15:0];
        end
    end

endmodule

`default_nettype wire

/* source/mgnt_top.sv */
`default_nettype none

module mgnt_top
    import mgnt_pkg::*;
#(
    parameter int FT_DEPTH = 16,
    parameter int DEV_REGS = 16
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              spi_wr,
    input  wire spi_cmd_t    spi_cmd,
    output logic             spi_ack,
    output logic [15:0]      spi_dout,
    input  wire [11:0]       lookup_hash,
    output logic             lookup_hit,
    output flow_t            lookup_flow
);

    sys_req_t    sys_req;
    sys_byte_t   sys_tx;
    sys_byte_t   sys_rx;
    logic        sys_ack;
    ft_cmd_t     ft_cmd;
    logic [11:0] ft_hash;
    flow_t       ft_flow;
    logic [1:0]  ft_busy;

    mgnt_reg_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .spi_wr   (spi_wr),
        .spi_cmd  (spi_cmd),
        .spi_ack  (spi_ack),
        .spi_dout (spi_dout),
        .sys_req  (sys_req),
        .sys_tx   (sys_tx),
        .sys_rx   (sys_rx),
        .sys_ack  (sys_ack),
        .ft_cmd   (ft_cmd),
        .ft_hash  (ft_hash),
        .ft_flow  (ft_flow),
        .ft_busy  (ft_busy)
    );

    // Remote MAC and switch endpoints
    mgnt_dev_bank #(
        .DEV_REGS (DEV_REGS)
    ) u_dev_bank (
        .clk      (clk),
        .rst      (rst),
        .sys_req  (sys_req),
        .sys_tx   (sys_tx),
        .sys_rx   (sys_rx),
        .sys_ack  (sys_ack)
    );

    flow_table #(
        .FT_DEPTH (FT_DEPTH)
    ) u_flow_table (
        .clk         (clk),
        .rst         (rst),
        .ft_cmd      (ft_cmd),
        .ft_hash     (ft_hash),
        .ft_flow     (ft_flow),
        .ft_busy     (ft_busy),
        .lookup_hash (lookup_hash),
        .lookup_hit  (lookup_hit),
        .lookup_flow (lookup_flow)
    );

endmodule

`default_nettype wire

/* bench/mgnt_tb.sv */
`default_nettype none

module mgnt_tb
    import mgnt_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FT_DEPTH    = 16;
    localparam int DEV_REGS    = 16;
    localparam int N_REMOTE    = 12;
    localparam int N_FLOWS     = 4;
    localparam int N_CLEARS    = 1;
    localparam int N_CMDS      = 11 + 5 * N_REMOTE + 12 + 10 * N_FLOWS + 3;
    localparam int N_LOOKUPS   = 3 * N_FLOWS;
    localparam int WDOG_CYCLES = (N_CMDS + N_LOOKUPS) * 40 + N_CLEARS * FT_DEPTH + 8;

    logic        clk;
    logic        rst;
    logic        spi_wr;
    spi_cmd_t    spi_cmd;
    logic        spi_ack;
    logic [15:0] spi_dout;
    logic [11:0] lookup_hash;
    logic        lookup_hit;
    flow_t       lookup_flow;

    // Reference model state
    logic [15:0] m_dev_data;
    logic [11:0] m_hash;
    logic [15:0] m_st [8];
    logic [31:0] m_dev [6][DEV_REGS];
    logic        m_clear_busy;
    logic        m_ft_valid [FT_DEPTH];
    logic [11:0] m_ft_tag [FT_DEPTH];
    flow_t       m_ft_flow [FT_DEPTH];

    dev_target_t all_tgts [6];
    logic [15:0] lfsr_state;
    logic [15:0] exp_dout;
    logic        exp_hit;
    flow_t       exp_flow;
    logic        ack_pending;
    logic        lkp_due;
    dev_target_t rec_tgt [N_REMOTE];
    logic [7:0]  rec_addr [N_REMOTE];
    logic [11:0] flow_hash [N_FLOWS];

    mgnt_top #(
        .FT_DEPTH (FT_DEPTH),
        .DEV_REGS (DEV_REGS)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .spi_wr      (spi_wr),
        .spi_cmd     (spi_cmd),
        .spi_ack     (spi_ack),
        .spi_dout    (spi_dout),
        .lookup_hash (lookup_hash),
        .lookup_hit  (lookup_hit),
        .lookup_flow (lookup_flow)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Random data and reference model
    ////////////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int slot_of(input dev_target_t tgt);
        int slot;
        slot = -1;
        for (int i = 0; i < 6; i++) begin
            if (all_tgts[i] == tgt) begin
                slot = i;
            end
        end
        return slot;
    endfunction

    function automatic logic [15:0] make_ptr(input logic wr, input dev_target_t tgt,
                                             input logic [7:0] addr);
        dev_ptr_t p;
        p.wr     = wr;
        p.target = tgt;
        p.addr   = addr;
        return p;
    endfunction

    // Staging word 0 is least significant
    function automatic flow_t staged_flow();
        logic [127:0] key;
        for (int i = 0; i < 8; i++) begin
            key[16*i +: 16] = m_st[i];
        end
        return key[119:0];
    endfunction

    function automatic logic [15:0] expected_dout(input spi_cmd_t cmd);
        dev_ptr_t    p;
        int          slot;
        logic [15:0] word;
        p    = dev_ptr_t'(cmd.din);
        slot = slot_of(p.target);
        word = cmd.din;
        if (cmd.op == OP_DEV_PTR) begin
            word = '0;
            if (slot >= 0) begin
                word = p.wr ? m_dev_data : m_dev[slot][p.addr % DEV_REGS][15:0];
            end else if (p.target == TGT_LOCAL) begin
                if (p.addr == LOC_DEV_DATA) begin
                    word = m_dev_data;
                end else if (p.addr == LOC_TABLE_CTRL) begin
                    word = {14'h0, m_clear_busy, 1'b0};
                end else if (p.addr == LOC_TABLE_HASH) begin
                    word = {4'h0, m_hash};
                end else if (p.addr >= 8'h30 && p.addr <= 8'h37) begin
                    word = m_st[p.addr[2:0]];
                end
            end
        end
        return word;
    endfunction

    function automatic logic ref_hit(input logic [11:0] hash);
        return m_ft_valid[hash % FT_DEPTH] && m_ft_tag[hash % FT_DEPTH] == hash;
    endfunction

    task automatic model_apply(input spi_cmd_t cmd);
        dev_ptr_t p;
        int       slot;
        int       idx;
        p    = dev_ptr_t'(cmd.din);
        slot = slot_of(p.target);
        idx  = m_hash % FT_DEPTH;
        case (cmd.op)
            OP_DEV_PTR: begin
                if (slot >= 0 && p.wr) begin
                    m_dev[slot][p.addr % DEV_REGS] = {16'h0, m_dev_data};
                end
            end
            OP_DEV_DATA:   m_dev_data = cmd.din;
            OP_TABLE_HASH: m_hash = cmd.din[11:0];
            OP_TABLE_CTRL: begin
                if (cmd.din == 16'd1 && !m_clear_busy) begin
                    m_ft_valid[idx] = 1'b1;
                    m_ft_tag[idx]   = m_hash;
                    m_ft_flow[idx]  = staged_flow();
                end else if (cmd.din == 16'd2) begin
                    m_clear_busy = 1'b1;
                end
            end
            // Staging words
            default: m_st[cmd.op[2:0]] = cmd.din;
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks and stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic send_cmd(input spi_op_t op, input logic [15:0] din, output int lat);
        spi_cmd_t cmd;
        cmd.op  = op;
        cmd.din = din;
        @(posedge clk);
        exp_dout    = expected_dout(cmd);
        ack_pending = 1'b1;
        spi_wr  <= 1'b1;
        spi_cmd <= cmd;
        lat = 0;
        @(negedge clk);
        while (!spi_ack) begin
            @(posedge clk);
            spi_wr <= 1'b0;
            lat++;
            @(negedge clk);
        end
        model_apply(cmd);
    endtask

    task automatic send_local(input spi_op_t op, input logic [15:0] din);
        int lat;
        send_cmd(op, din, lat);
        check_value("ack_latency", lat, 3);
    endtask

    task automatic send_remote(input logic [15:0] ptr);
        int lat;
        send_cmd(OP_DEV_PTR, ptr, lat);
        if (lat < MGNT_BYTES + 4) begin
            fail_run("Remote transfer was acknowledged too early");
        end
    endtask

    task automatic run_lookup(input logic [11:0] hash);
        @(posedge clk);
        lookup_hash <= hash;
        exp_hit  = ref_hit(hash);
        exp_flow = exp_hit ? m_ft_flow[hash % FT_DEPTH] : '0;
        @(posedge clk);
        lkp_due = 1'b1;
        wait (!lkp_due);
    endtask

    // Compare on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (spi_ack) begin
            if (!ack_pending) begin
                fail_run("spi_ack pulsed with no command outstanding");
            end
            check_value("spi_dout", spi_dout, exp_dout);
            ack_pending = 1'b0;
        end
        if (lkp_due) begin
            check_value("lookup_hit", lookup_hit, exp_hit);
            check_value("lookup_flow", lookup_flow, exp_flow);
            lkp_due = 1'b0;
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WDOG_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        spi_wr       = 1'b0;
        spi_cmd      = '0;
        lookup_hash  = '0;
        lfsr_state   = 16'd57;
        ack_pending  = 1'b0;
        lkp_due      = 1'b0;
        all_tgts     = '{TGT_PORT0, TGT_PORT1, TGT_PORT2, TGT_PORT3, TGT_BE_SW, TGT_TTE_SW};
        m_dev_data   = '0;
        m_hash       = '0;
        m_clear_busy = 1'b0;
        for (int i = 0; i < 8; i++) begin
            m_st[i] = '0;
        end
        for (int d = 0; d < 6; d++) begin
            for (int r = 0; r < DEV_REGS; r++) begin
                m_dev[d][r] = '0;
            end
        end
        for (int i = 0; i < FT_DEPTH; i++) begin
            m_ft_valid[i] = 1'b0;
            m_ft_tag[i]   = '0;
            m_ft_flow[i]  = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_value("spi_ack", spi_ack, 0);
        check_value("lookup_hit", lookup_hit, 0);

        // Local writes echo din after three cycles
        send_local(OP_DEV_DATA, 16'(rand_bits(16)));
        send_local(OP_TABLE_HASH, 16'(rand_bits(16)));
        for (int i = 0; i < 8; i++) begin
            send_local(spi_op_t'(OP_TABLE_ST0 + i), 16'(rand_bits(16)));
        end
        send_local(OP_TABLE_CTRL, 16'(rand_bits(16)) | 16'h0100);

        // Remote round trips with the first six covering every endpoint
        for (int i = 0; i < N_REMOTE; i++) begin
            rec_tgt[i]  = (i < 6) ? all_tgts[i] : all_tgts[rand_bits(8) % 6];
            rec_addr[i] = 8'(rand_bits(8));
            send_local(OP_DEV_DATA, 16'(rand_bits(16)));
            send_remote(make_ptr(1'b1, rec_tgt[i], rec_addr[i]));
            send_remote(make_ptr(1'b0, rec_tgt[i], rec_addr[i]));
        end
        // Same address on the next endpoint must be untouched
        for (int i = 0; i < N_REMOTE; i++) begin
            send_remote(make_ptr(1'b0, rec_tgt[i], rec_addr[i]));
            send_remote(make_ptr(1'b0, all_tgts[(slot_of(rec_tgt[i]) + 1) % 6],
                                 rec_addr[i]));
        end

        // Local read-back
        send_local(OP_DEV_PTR, make_ptr(1'b0, TGT_LOCAL, LOC_DEV_DATA));
        send_local(OP_DEV_PTR, make_ptr(1'b0, TGT_LOCAL, LOC_TABLE_HASH));
        for (int i = 0; i < 8; i++) begin
            send_local(OP_DEV_PTR, make_ptr(1'b0, TGT_LOCAL, LOC_TABLE_ST + 8'(i)));
        end
        send_local(OP_DEV_PTR, make_ptr(1'b0, TGT_LOCAL, 8'h20));
        send_local(OP_DEV_PTR, make_ptr(1'b0, dev_target_t'(7'h10), 8'h01));

        // Flow insert then hit and same-index miss
        for (int f = 0; f < N_FLOWS; f++) begin
            for (int i = 0; i < 8; i++) begin
                send_local(spi_op_t'(OP_TABLE_ST0 + i), 16'(rand_bits(16)));
            end
            flow_hash[f] = 12'(rand_bits(12));
            send_local(OP_TABLE_HASH, {4'h0, flow_hash[f]});
            send_local(OP_TABLE_CTRL, 16'd1);
            run_lookup(flow_hash[f]);
            run_lookup(flow_hash[f] ^ 12'h100);
        end

        // Clear sweep
        send_local(OP_TABLE_CTRL, 16'd2);
        send_local(OP_DEV_PTR, make_ptr(1'b0, TGT_LOCAL, LOC_TABLE_CTRL));
        repeat (FT_DEPTH) @(posedge clk);
        m_clear_busy = 1'b0;
        for (int i = 0; i < FT_DEPTH; i++) begin
            m_ft_valid[i] = 1'b0;
        end
        send_local(OP_DEV_PTR, make_ptr(1'b0, TGT_LOCAL, LOC_TABLE_CTRL));
        for (int f = 0; f < N_FLOWS; f++) begin
            run_lookup(flow_hash[f]);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
source/mgnt_pkg.sv
source/flow_table.sv
source/mgnt_dev_bank.sv
source/mgnt_reg_ctrl.sv
source/mgnt_top.sv
bench/mgnt_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module mgnt_tb -f filelist.f

status=0
./obj_dir/Vmgnt_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed (exit status $status)"
    exit 1
fi
echo "Simulation passed"
